// ==== rtl/obj_config.svh ====
`ifndef OBJ_CONFIG_SVH
`define OBJ_CONFIG_SVH

// Object table size in entries, four bytes each
`define OBJ_ENTRIES 64

// Pixels between hdump and line-buffer address
`define OBJ_HOFFSET 6

// Line on which the CPU bank is copied into the frame table
`define OBJ_COPY_LINE 64

// Line on which the frame table halves swap
`define OBJ_FLIP_LINE 8

// Object height in lines
`define OBJ_HEIGHT 16

`endif

// ==== rtl/obj_draw.sv ====
`timescale 1ns/1ps

module obj_draw (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   draw,
    input  obj_pkg::obj_entry_t    entry,
    output logic                   busy,
    output logic                   rom_cs,
    output obj_pkg::obj_rom_addr_t rom_addr,
    input  obj_pkg::obj_rom_data_t rom_data,
    input  logic                   rom_ok,
    output obj_pkg::obj_pix_wr_t   pix_wr
);
    import obj_pkg::*;

    draw_state_t   state;
    obj_entry_t    cur;
    obj_rom_data_t pix_sr;
    obj_ysub_t     row;
    obj_xpos_t     xcur;
    obj_xpos_t     wr_addr;
    obj_pix_t      wr_raw;
    logic          wr_we;
    logic          half;
    logic [2:0]    pix_cnt;

    assign busy = state != DRAW_IDLE;
    assign row  = cur.vflip ? ~cur.ysub : cur.ysub;

    // hflip fetches the right half first
    assign rom_addr = {cur.code, row, half ^ cur.hflip};

    assign pix_wr = '{we: wr_we, addr: wr_addr, pal: cur.pal, raw: wr_raw};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= DRAW_IDLE;
            rom_cs  <= 1'b0;
            half    <= 1'b0;
            pix_cnt <= '0;
            wr_we   <= 1'b0;
        end else begin
            wr_we <= 1'b0;
            case (state)
                DRAW_IDLE: begin
                    if (draw) begin
                        half   <= 1'b0;
                        rom_cs <= 1'b1;
                        state  <= DRAW_FETCH;
                    end
                end
                DRAW_FETCH: begin
                    // Address stays put until the ROM answers
                    if (rom_ok) begin
                        rom_cs  <= 1'b0;
                        pix_cnt <= '0;
                        state   <= DRAW_PIXELS;
                    end
                end
                DRAW_PIXELS: begin
                    wr_we   <= 1'b1;
                    pix_cnt <= pix_cnt + 3'd1;
                    if (&pix_cnt) begin
                        if (!half) begin
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            state  <= DRAW_FETCH;
                        end else begin
                            state <= DRAW_IDLE;
                        end
                    end
                end
                default: state <= DRAW_IDLE;
            endcase
        end
    end

    // Pixel shifter, nibble order reversed for hflip
    always_ff @(posedge clk) begin
        if (state == DRAW_IDLE && draw) begin
            cur  <= entry;
            xcur <= entry.xpos;
        end
        if (state == DRAW_FETCH && rom_ok)
            pix_sr <= rom_data;
        if (state == DRAW_PIXELS) begin
            wr_addr <= xcur;
            wr_raw  <= cur.hflip ? pix_sr[3:0] : pix_sr[31:28];
            pix_sr  <= cur.hflip ? pix_sr >> 4 : pix_sr << 4;
            xcur    <= xcur + 8'd1;
        end
    end

endmodule

// ==== rtl/obj_engine.sv ====
`timescale 1ns/1ps

module obj_engine (
    input  logic                   clk,
    input  logic                   rst,
    // CPU port
    input  logic [9:0]             cpu_addr,
    input  logic [7:0]             cpu_dout,
    input  logic                   obj_cs,
    input  logic                   cpu_rnw,
    input  logic                   obj_frame,
    output logic [7:0]             obj_dout,
    // Video timing
    input  logic                   pxl_cen,
    input  logic                   hinit,
    input  logic                   LHBL,
    input  logic                   LVBL,
    input  logic [7:0]             vrender,
    input  logic [8:0]             hdump,
    // Palette PROM programming
    input  logic [7:0]             prog_addr,
    input  obj_pkg::obj_pix_t      prog_data,
    input  logic                   prog_en,
    // Graphics ROM
    output logic                   rom_cs,
    output obj_pkg::obj_rom_addr_t rom_addr,
    input  obj_pkg::obj_rom_data_t rom_data,
    input  logic                   rom_ok,
    output obj_pkg::obj_pix_t      pxl
);
    import obj_pkg::*;

    obj_video_t  video;
    obj_entry_t  entry;
    obj_pix_wr_t pix_wr;
    obj_buf_wr_t buf_wr;
    obj_pix_t    line_pxl;
    logic [7:0]  rd_addr;
    logic [7:0]  rd_data;
    logic        scan_cen;
    logic        busy;
    logic        draw;

    assign video = '{hinit: hinit, lhbl: LHBL, vrender: vrender, hdump: hdump};

    // Blank objects during vertical blanking
    assign pxl = LVBL ? line_pxl : '0;

    // Scanner runs at half the clock rate
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            scan_cen <= 1'b0;
        else
            scan_cen <= ~scan_cen;
    end

    obj_ram i_obj_ram (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .obj_cs    (obj_cs),
        .cpu_rnw   (cpu_rnw),
        .obj_frame (obj_frame),
        .obj_dout  (obj_dout),
        .video     (video),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    obj_scan i_obj_scan (
        .clk      (clk),
        .rst      (rst),
        .scan_cen (scan_cen),
        .video    (video),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .busy     (busy),
        .entry    (entry),
        .draw     (draw)
    );

    obj_draw i_obj_draw (
        .clk      (clk),
        .rst      (rst),
        .draw     (draw),
        .entry    (entry),
        .busy     (busy),
        .rom_cs   (rom_cs),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .pix_wr   (pix_wr)
    );

    obj_pal_lut i_obj_pal_lut (
        .clk       (clk),
        .rst       (rst),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .pix_wr    (pix_wr),
        .buf_wr    (buf_wr)
    );

    obj_line_buf i_obj_line_buf (
        .clk     (clk),
        .rst     (rst),
        .video   (video),
        .pxl_cen (pxl_cen),
        .buf_wr  (buf_wr),
        .pxl     (line_pxl)
    );

endmodule

// ==== rtl/obj_line_buf.sv ====
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_line_buf (
    input  logic                 clk,
    input  logic                 rst,
    input  obj_pkg::obj_video_t  video,
    input  logic                 pxl_cen,
    input  obj_pkg::obj_buf_wr_t buf_wr,
    output obj_pkg::obj_pix_t    pxl
);
    import obj_pkg::*;

    // Two line halves, lsel picks the one being drawn
    obj_pix_t  line_mem [0:511];
    logic      lsel;
    logic      hinit_q;
    logic      free;
    obj_xpos_t rd_addr;

    assign rd_addr = video.hdump[7:0] - 8'(`OBJ_HOFFSET);
    // First object written to a pixel keeps it
    assign free    = line_mem[{lsel, buf_wr.addr}] == '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lsel    <= 1'b0;
            hinit_q <= 1'b0;
            pxl     <= '0;
        end else begin
            hinit_q <= video.hinit;
            if (video.hinit && !hinit_q)
                lsel <= ~lsel;
            if (pxl_cen)
                pxl <= video.lhbl ? line_mem[{~lsel, rd_addr}] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_wr.we && free)
            line_mem[{lsel, buf_wr.addr}] <= buf_wr.color;
        // Clear behind the read so the half is empty for its next line
        if (pxl_cen)
            line_mem[{~lsel, rd_addr}] <= '0;
    end

endmodule

// ==== rtl/obj_pal_lut.sv ====
`timescale 1ns/1ps

module obj_pal_lut (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [7:0]           prog_addr,
    input  obj_pkg::obj_pix_t    prog_data,
    input  logic                 prog_en,
    input  obj_pkg::obj_pix_wr_t pix_wr,
    output obj_pkg::obj_buf_wr_t buf_wr
);
    import obj_pkg::*;

    // Indexed by palette in the top nibble, raw pixel below
    obj_pix_t  lut [0:255];
    obj_pix_t  color;
    obj_pix_t  wr_color;
    obj_xpos_t wr_addr;
    logic      wr_we;

    assign color  = lut[{pix_wr.pal, pix_wr.raw}];
    assign buf_wr = '{we: wr_we, addr: wr_addr, color: wr_color};

    always_ff @(posedge clk) begin
        if (prog_en)
            lut[prog_addr] <= prog_data;
    end

    // Colour 0 is transparent, nothing gets written
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            wr_we <= 1'b0;
        else
            wr_we <= pix_wr.we && (color != '0);
    end

    always_ff @(posedge clk) begin
        wr_addr  <= pix_wr.addr;
        wr_color <= color;
    end

endmodule

// ==== rtl/obj_pkg.sv ====
package obj_pkg;

    typedef logic [8:0]  obj_code_t;
    typedef logic [7:0]  obj_xpos_t;
    typedef logic [3:0]  obj_pal_t;
    typedef logic [3:0]  obj_ysub_t;
    typedef logic [3:0]  obj_pix_t;
    typedef logic [13:0] obj_rom_addr_t;
    // Eight pixels, leftmost in the top nibble
    typedef logic [31:0] obj_rom_data_t;

    // One object as the scanner hands it to the drawer
    typedef struct packed {
        obj_code_t code;
        obj_xpos_t xpos;
        obj_pal_t  pal;
        logic      hflip;
        logic      vflip;
        obj_ysub_t ysub;
    } obj_entry_t;

    // Raw pixel from the drawer, before the palette
    typedef struct packed {
        logic      we;
        obj_xpos_t addr;
        obj_pal_t  pal;
        obj_pix_t  raw;
    } obj_pix_wr_t;

    // Coloured pixel into the line buffer
    typedef struct packed {
        logic      we;
        obj_xpos_t addr;
        obj_pix_t  color;
    } obj_buf_wr_t;

    typedef struct packed {
        logic       hinit;
        logic       lhbl;
        logic [7:0] vrender;
        logic [8:0] hdump;
    } obj_video_t;

    typedef enum logic [1:0] {SCAN_Y, SCAN_X, SCAN_ATTR, SCAN_CODE} scan_state_t;

    typedef enum logic [1:0] {DRAW_IDLE, DRAW_FETCH, DRAW_PIXELS} draw_state_t;

endpackage

// ==== rtl/obj_ram.sv ====
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_ram (
    input  logic               clk,
    input  logic               rst,
    input  logic [9:0]         cpu_addr,
    input  logic [7:0]         cpu_dout,
    input  logic               obj_cs,
    input  logic               cpu_rnw,
    input  logic               obj_frame,
    output logic [7:0]         obj_dout,
    input  obj_pkg::obj_video_t video,
    input  logic [7:0]         rd_addr,
    output logic [7:0]         rd_data
);

    // Two 256-byte banks in the lower half of the CPU RAM
    logic [7:0] cpu_ram [0:1023];
    // Frame table, two halves of 256 bytes
    logic [7:0] frame_tbl [0:511];

    logic       fr;
    logic       hinit_q;
    logic       copy_en;
    logic       flip_en;
    logic       copy_we;
    logic [7:0] copy_addr;
    logic [7:0] copy_data;

    assign copy_en = video.lhbl && (video.vrender == 8'(`OBJ_COPY_LINE));
    assign flip_en = video.hinit && !hinit_q && (video.vrender == 8'(`OBJ_FLIP_LINE));

    // CPU side
    always_ff @(posedge clk) begin
        if (obj_cs && !cpu_rnw)
            cpu_ram[cpu_addr] <= cpu_dout;
        if (obj_cs && cpu_rnw)
            obj_dout <= cpu_ram[cpu_addr];
    end

    // Copy read, byte order code,attr,x,y becomes y,x,attr,code
    always_ff @(posedge clk) begin
        copy_data <= cpu_ram[{1'b0, obj_frame, video.hdump[7:0]}];
        copy_addr <= video.hdump[7:0] ^ 8'h03;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fr      <= 1'b0;
            hinit_q <= 1'b0;
            copy_we <= 1'b0;
        end else begin
            hinit_q <= video.hinit;
            copy_we <= copy_en;
            if (flip_en)
                fr <= ~fr;
        end
    end

    // Copy writes half fr, scanner reads the other one
    always_ff @(posedge clk) begin
        if (copy_we)
            frame_tbl[{fr, copy_addr}] <= copy_data;
        rd_data <= frame_tbl[{~fr, rd_addr}];
    end

endmodule

// ==== rtl/obj_scan.sv ====
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_scan (
    input  logic                clk,
    input  logic                rst,
    input  logic                scan_cen,
    input  obj_pkg::obj_video_t video,
    output logic [7:0]          rd_addr,
    input  logic [7:0]          rd_data,
    input  logic                busy,
    output obj_pkg::obj_entry_t entry,
    output logic                draw
);
    import obj_pkg::*;

    scan_state_t state;
    logic [5:0]  obj_cnt;
    logic        done;
    logic [7:0]  ydiff;
    logic        in_range;
    logic        last_obj;
    logic        step;

    // Byte within the entry follows the state
    assign rd_addr  = {obj_cnt, state};
    assign ydiff    = video.vrender - rd_data;
    assign in_range = ydiff < 8'(`OBJ_HEIGHT);
    assign last_obj = obj_cnt == 6'(`OBJ_ENTRIES - 1);
    assign step     = scan_cen && !done && !video.hinit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= SCAN_Y;
            obj_cnt <= '0;
            done    <= 1'b0;
            draw    <= 1'b0;
        end else begin
            draw <= 1'b0;
            if (video.hinit) begin
                state   <= SCAN_Y;
                obj_cnt <= '0;
                done    <= 1'b0;
            end else if (step) begin
                case (state)
                    SCAN_Y: begin
                        if (in_range) begin
                            state <= SCAN_X;
                        end else begin
                            obj_cnt <= obj_cnt + 6'd1;
                            done    <= last_obj;
                        end
                    end
                    SCAN_X:    state <= SCAN_ATTR;
                    SCAN_ATTR: state <= SCAN_CODE;
                    SCAN_CODE: begin
                        // Only this step waits for the drawer
                        if (!busy) begin
                            draw    <= 1'b1;
                            state   <= SCAN_Y;
                            obj_cnt <= obj_cnt + 6'd1;
                            done    <= last_obj;
                        end
                    end
                    default: state <= SCAN_Y;
                endcase
            end
        end
    end

    // Entry fields collected byte by byte
    always_ff @(posedge clk) begin
        if (step) begin
            case (state)
                SCAN_Y:    entry.ysub <= ydiff[3:0];
                SCAN_X:    entry.xpos <= rd_data;
                SCAN_ATTR: begin
                    entry.pal     <= rd_data[3:0];
                    entry.code[8] <= rd_data[5];
                    entry.hflip   <= rd_data[6];
                    entry.vflip   <= rd_data[7];
                end
                SCAN_CODE: if (!busy) entry.code[7:0] <= rd_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/obj_pkg.sv
rtl/obj_ram.sv
rtl/obj_scan.sv
rtl/obj_draw.sv
rtl/obj_pal_lut.sv
rtl/obj_line_buf.sv
rtl/obj_engine.sv
verification/obj_engine_tb.sv

// ==== verification/obj_engine_tb.sv ====
`timescale 1ns/1ps
`include "obj_config.svh"

module obj_engine_tb;
    import obj_pkg::*;

    localparam int FRAME_CYCLES   = 384 * 2 * 264;
    // Longest test waits for line 100, then two frame starts, then checks to line 240
    localparam int TIMEOUT_CYCLES = 4 * FRAME_CYCLES;
    localparam logic [7:0] HIDDEN_Y = 8'hF0;

    logic          clk = 1'b0;
    logic          rst;
    logic [9:0]    cpu_addr;
    logic [7:0]    cpu_dout;
    logic          obj_cs;
    logic          cpu_rnw;
    logic          obj_frame;
    logic [7:0]    obj_dout;
    logic          pxl_cen = 1'b0;
    logic [8:0]    hdump = '0;
    logic [8:0]    vcnt = '0;
    logic          hinit;
    logic          LHBL;
    logic          LVBL;
    logic [7:0]    vrender;
    logic [7:0]    prog_addr;
    obj_pix_t      prog_data;
    logic          prog_en;
    logic          rom_cs;
    obj_rom_addr_t rom_addr;
    obj_rom_data_t rom_data = '0;
    logic          rom_ok = 1'b0;
    obj_pix_t      pxl;

    // Shadow copies of the CPU RAM and the palette PROM
    logic [7:0]    ram_model [0:1023];
    obj_pix_t      lut_model [0:255];
    logic          ref_bank = 1'b0;
    int            checks = 0;
    int            errors = 0;
    int            cycle = 0;
    int            test_start = 0;
    logic          checking = 1'b0;
    logic          cmp_pending = 1'b0;
    logic [8:0]    cmp_h = '0;
    logic [7:0]    cmp_v = '0;
    logic [31:0]   rom_rng = 32'd53204;
    logic [31:0]   stim_rng = 32'd53204;
    int            rom_wait = 0;
    int            rom_delay = 0;
    obj_rom_addr_t rom_req = '0;

    always #10 clk = ~clk;

    // 384 pixels per line, 264 lines per frame
    assign hinit   = hdump == 9'd0;
    assign LHBL    = hdump < 9'd256;
    assign LVBL    = vcnt >= 9'd16 && vcnt < 9'd240;
    assign vrender = vcnt[7:0];

    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
        if (pxl_cen) begin
            if (hdump == 9'd383) begin
                hdump <= '0;
                vcnt  <= (vcnt == 9'd263) ? 9'd0 : vcnt + 9'd1;
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    obj_engine i_obj_engine (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_dout  (cpu_dout),
        .obj_cs    (obj_cs),
        .cpu_rnw   (cpu_rnw),
        .obj_frame (obj_frame),
        .obj_dout  (obj_dout),
        .pxl_cen   (pxl_cen),
        .hinit     (hinit),
        .LHBL      (LHBL),
        .LVBL      (LVBL),
        .vrender   (vrender),
        .hdump     (hdump),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_en   (prog_en),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .pxl       (pxl)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic obj_rom_data_t rom_word(input obj_rom_addr_t a);
        return (32'(a) * 32'h9E3779B1) ^ {a, 18'h2A5C3};
    endfunction

    // Expected pixel at hdump h on the line showing vdisp
    function automatic obj_pix_t expected_pixel(input logic [7:0] vdisp, input logic [8:0] h);
        logic [7:0]    vs;
        logic [7:0]    dy;
        logic [7:0]    col;
        logic [7:0]    attr;
        logic [9:0]    base;
        obj_ysub_t     row;
        logic          half;
        obj_rom_data_t w;
        obj_pix_t      raw;
        obj_pix_t      result;
        result = '0;
        // Objects on screen were scanned on the previous line
        vs = vdisp - 8'd1;
        if (h >= 9'd256)
            return '0;
        for (int i = 0; i < `OBJ_ENTRIES; i++) begin
            base = {1'b0, ref_bank, 6'(i), 2'b00};
            attr = ram_model[base + 10'd1];
            dy   = vs - ram_model[base + 10'd3];
            col  = h[7:0] - ram_model[base + 10'd2] - 8'(`OBJ_HOFFSET);
            if (dy < 8'(`OBJ_HEIGHT) && col < 8'd16 && result == '0) begin
                row  = attr[7] ? ~dy[3:0] : dy[3:0];
                half = col[3] ^ attr[6];
                w    = rom_word({attr[5], ram_model[base], row, half});
                raw  = attr[6] ? w[4 * col[2:0] +: 4] : w[28 - 4 * col[2:0] +: 4];
                result = lut_model[{attr[3:0], raw}];
            end
        end
        return result;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // ROM answers 1 to 6 clocks after rom_cs
    always @(posedge clk) begin
        rom_ok <= 1'b0;
        if (rom_cs && !rom_ok) begin
            if (rom_wait == 0)
                rom_req <= rom_addr;
            else
                check_value(rom_addr, rom_req, "rom_addr held until rom_ok");
            if (rom_wait >= rom_delay) begin
                rom_ok    <= 1'b1;
                rom_data  <= rom_word(rom_addr);
                rom_wait  <= 0;
                rom_delay <= int'(rom_rng % 6);
                rom_rng   <= xorshift32(rom_rng);
            end else begin
                rom_wait <= rom_wait + 1;
            end
        end
    end

    // pxl settles one clock after the pixel enable
    always @(posedge clk) begin
        if (cmp_pending)
            check_value(pxl, expected_pixel(cmp_v, cmp_h),
                        $sformatf("pxl line %0d h %0d", cmp_v, cmp_h));
        cmp_pending <= pxl_cen && checking && LVBL;
        cmp_h       <= hdump;
        cmp_v       <= vrender;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle - test_start > TIMEOUT_CYCLES) begin
            $display("Timeout: a test ran longer than %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic next_rand(output logic [31:0] r);
        stim_rng = xorshift32(stim_rng);
        r = stim_rng;
    endtask

    task automatic cpu_write(input logic [9:0] a, input logic [7:0] d);
        @(posedge clk);
        obj_cs   <= 1'b1;
        cpu_rnw  <= 1'b0;
        cpu_addr <= a;
        cpu_dout <= d;
        @(posedge clk);
        obj_cs <= 1'b0;
        ram_model[a] = d;
    endtask

    task automatic cpu_read(input logic [9:0] a, output logic [7:0] d);
        @(posedge clk);
        obj_cs   <= 1'b1;
        cpu_rnw  <= 1'b1;
        cpu_addr <= a;
        @(posedge clk);
        obj_cs <= 1'b0;
        @(posedge clk);
        d = obj_dout;
    endtask

    // CPU byte order is code, attr, x, y
    task automatic set_object(input logic bank, input logic [5:0] idx, input logic [7:0] y,
                              input logic [7:0] x, input logic [8:0] code, input logic [3:0] pal,
                              input logic hflip, input logic vflip);
        logic [9:0] base;
        base = {1'b0, bank, idx, 2'b00};
        cpu_write(base, code[7:0]);
        cpu_write(base + 10'd1, {vflip, hflip, code[8], 1'b0, pal});
        cpu_write(base + 10'd2, x);
        cpu_write(base + 10'd3, y);
    endtask

    task automatic wait_line(input logic [8:0] n);
        while (vcnt == n)
            @(posedge clk);
        while (vcnt != n)
            @(posedge clk);
    endtask

    // Table written near line 100 is copied next frame and shown the frame after
    task automatic check_frame(input logic bank);
        ref_bank = bank;
        wait_line(0);
        wait_line(0);
        wait_line(16);
        checking <= 1'b1;
        wait_line(240);
        checking <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "errors");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [9:0]  addrs [0:31];
        logic [7:0]  rd;
        int          err0;
        rst       = 1'b1;
        cpu_addr  = '0;
        cpu_dout  = '0;
        obj_cs    = 1'b0;
        cpu_rnw   = 1'b1;
        obj_frame = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // Palette 3 has odd raw pixels transparent
        for (int a = 0; a < 256; a++) begin
            next_rand(r);
            if (a[7:4] == 4'd3 && a[0])
                r[3:0] = 4'd0;
            @(posedge clk);
            prog_en   <= 1'b1;
            prog_addr <= 8'(a);
            prog_data <= r[3:0];
            lut_model[a] = r[3:0];
        end
        @(posedge clk);
        prog_en <= 1'b0;

        test_start = cycle;
        err0 = errors;
        for (int i = 0; i < 32; i++) begin
            next_rand(r);
            addrs[i] = r[9:0];
            cpu_write(r[9:0], r[17:10]);
        end
        for (int i = 0; i < 32; i++) begin
            cpu_read(addrs[i], rd);
            check_value(rd, ram_model[addrs[i]], $sformatf("read back %0h", addrs[i]));
        end
        report_test(1, "cpu read back", err0);

        // Park every entry of both banks below the checked lines
        for (int i = 0; i < 128; i++)
            set_object(i[6], i[5:0], HIDDEN_Y, 8'd0, 9'd0, 4'd0, 1'b0, 1'b0);

        test_start = cycle;
        err0 = errors;
        wait_line(100);
        next_rand(r);
        next_rand(r2);
        set_object(1'b0, 6'd0, 8'd40 + 8'(r2 % 160), r[7:0], r[16:8], r[23:20], 1'b0, 1'b0);
        check_frame(1'b0);
        report_test(2, "single object", err0);

        test_start = cycle;
        err0 = errors;
        wait_line(100);
        next_rand(r);
        set_object(1'b0, 6'd0, 8'd60, 8'd20, r[8:0], 4'd2, 1'b1, 1'b0);
        set_object(1'b0, 6'd1, 8'd100, 8'd120, r[17:9], 4'd6, 1'b0, 1'b1);
        set_object(1'b0, 6'd2, 8'd150, 8'd250, r[26:18], 4'd9, 1'b1, 1'b1);
        check_frame(1'b0);
        report_test(3, "flipped objects", err0);

        test_start = cycle;
        err0 = errors;
        wait_line(100);
        next_rand(r);
        set_object(1'b0, 6'd0, 8'd80, 8'd50, r[8:0], 4'd3, 1'b0, 1'b0);
        set_object(1'b0, 6'd1, 8'd84, 8'd56, r[17:9], 4'd5, 1'b0, 1'b0);
        set_object(1'b0, 6'd2, 8'd88, 8'd44, r[26:18], 4'd3, 1'b1, 1'b0);
        check_frame(1'b0);
        report_test(4, "overlap priority", err0);

        test_start = cycle;
        err0 = errors;
        wait_line(100);
        next_rand(r);
        set_object(1'b1, 6'd0, 8'd120, 8'd30, r[8:0], 4'd4, 1'b0, 1'b0);
        set_object(1'b1, 6'd5, 8'd124, 8'd36, r[17:9], 4'd3, 1'b0, 1'b1);
        check_frame(1'b0);
        report_test(5, "bank 1 not shown", err0);

        test_start = cycle;
        err0 = errors;
        wait_line(100);
        @(posedge clk);
        obj_frame <= 1'b1;
        check_frame(1'b1);
        report_test(6, "bank 1 shown", err0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
